//--- hw/fll_cfg_pkg.sv
// Structural widths and typedefs for counts, ratios, trim code and trim word
package fll_cfg_pkg;

    // Feedback ratio, clock cycles wanted per osc period
    parameter int div_w = 5;

    // Period measurement, saturates at all ones (255)
    parameter int count_w = 8;

    // Delay stages in each of the two ring chains
    parameter int num_stages = 13;

    // Trim code covers 0 .. 2*num_stages, so 0 .. 26 by default
    parameter int code_w = 5;

    // Feedback ratio as seen on the div port
    typedef logic [div_w-1:0] div_t;

    // Clock cycles counted over one osc period
    typedef logic [count_w-1:0] count_t;

    // Number of trim bits to set, one step per measurement at most
    typedef logic [code_w-1:0] code_t;

endpackage

//--- hw/fll_ctrl_pkg.sv
// Control-law constants: tolerance band, lock run length and trim code limits
package fll_ctrl_pkg;

    // Allowed count deviation from div, same width as a measurement
    parameter fll_cfg_pkg::count_t band_tol = 8'd1;

    // In-band measurements in a row before locked goes high
    parameter logic [2:0] lock_run = 3'd4;

    // Lowest trim code, no trim bits set, fastest ring
    parameter fll_cfg_pkg::code_t code_min = 5'd0;

    // Code change per out-of-band measurement
    // Kept at one so the trim word moves a single bit at a time
    parameter fll_cfg_pkg::code_t code_step = 5'd1;

endpackage

//--- hw/fll_osc_sampler.sv
// Osc synchronizer, rising edge detector and clock-cycles-per-period counter
`timescale 1ns/100ps
`default_nettype none

module fll_osc_sampler #(
    parameter int sync_stages = 2                  // Flops in osc synchronizer, at least 2
) (
    input  logic                 clock,            // Ring oscillator output, fed back
    input  logic                 arst_n,           // Async reset, active low
    input  logic                 enable,           // Measurement enable
    input  logic                 osc,              // Slow reference, asynchronous to clock
    output fll_cfg_pkg::count_t  period_count,     // Clock cycles in last osc period
    output logic                 period_valid      // One-cycle strobe, new period_count
);

    import fll_cfg_pkg::*;

    logic [sync_stages-1:0] sync_q;                // Osc synchronizer chain
    logic                   osc_s;                 // Synchronized osc
    logic                   osc_d;                 // Synchronized osc, one cycle late
    logic                   osc_rise;              // Rising edge of synchronized osc
    logic                   seen_q;                // An edge has started a measurement
    count_t                 cycle_cnt;             // Cycles since last detected edge
    count_t                 cycle_inc;             // Saturating increment of cycle_cnt

    assign osc_s    = sync_q[sync_stages-1];
    assign osc_rise = osc_s & ~osc_d;

    // Hold at all ones once the period gets too long to count
    assign cycle_inc = (cycle_cnt == '1) ? cycle_cnt : cycle_cnt + count_t'(1);

    // Synchronizer and edge delay, run regardless of enable
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sync_q <= '0;
            osc_d  <= 1'b0;
        end else begin
            sync_q <= {sync_q[sync_stages-2:0], osc};  // Shift osc in at the bottom
            osc_d  <= osc_s;
        end
    end

    // Cycle counter and strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt    <= '0;
            seen_q       <= 1'b0;
            period_valid <= 1'b0;
        end else if (!enable) begin
            // Disabled, forget any partial period so the next edge only restarts
            cycle_cnt    <= '0;
            seen_q       <= 1'b0;
            period_valid <= 1'b0;
        end else if (osc_rise) begin
            cycle_cnt    <= count_t'(1);           // Edge cycle is first of new period
            seen_q       <= 1'b1;
            period_valid <= seen_q;                // No strobe on the very first edge
        end else begin
            cycle_cnt    <= cycle_inc;
            period_valid <= 1'b0;
        end
    end

    // Measurement register, only read when period_valid is high
    always_ff @(posedge clock) begin
        if (osc_rise) begin
            period_count <= cycle_cnt;             // Cycles from previous edge to this one
        end
    end

endmodule

`default_nettype wire

//--- hw/fll_trim_controller.sv
// Trim controller comparing each period count with div, stepping the code and tracking lock
`timescale 1ns/100ps
`default_nettype none

module fll_trim_controller #(
    parameter int num_stages = fll_cfg_pkg::num_stages  // Stages per chain
) (
    input  logic                 clock,            // Ring oscillator output
    input  logic                 arst_n,           // Async reset, active low
    input  fll_cfg_pkg::div_t    div,              // Target clock cycles per osc period
    input  fll_cfg_pkg::count_t  period_count,     // Measured clock cycles per osc period
    input  logic                 period_valid,     // New measurement this cycle
    output fll_cfg_pkg::code_t   trim_code,        // Number of trim bits to set
    output logic                 locked            // Count has stayed in band
);

    import fll_cfg_pkg::*;
    import fll_ctrl_pkg::*;

    // Highest code, every stage of both chains trimmed
    localparam code_t code_max = code_t'(2 * num_stages);

    logic [count_w:0] cnt_ext;                     // Count with headroom bit
    logic [count_w:0] div_ext;                     // div widened to match
    logic [count_w:0] tol_ext;                     // Band tolerance widened
    logic             too_fast;                    // Count above upper band edge
    logic             too_slow;                    // Count below lower band edge
    logic             in_band;
    logic [2:0]       run_cnt;                     // In-band strobes in a row

    assign cnt_ext = {1'b0, period_count};
    assign div_ext = (count_w + 1)'(div);
    assign tol_ext = {1'b0, band_tol};

    // More clock cycles than wanted means the ring runs fast
    assign too_fast = cnt_ext > (div_ext + tol_ext);

    // Compare as count + tol < div, no wrap when div is below the tolerance
    assign too_slow = (cnt_ext + tol_ext) < div_ext;
    assign in_band  = !too_fast && !too_slow;

    // Code update, one step per measurement
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            trim_code <= code_min;
        end else if (period_valid) begin
            if (too_fast && (trim_code < code_max)) begin
                trim_code <= trim_code + code_step;   // Load one more stage, slow down
            end else if (too_slow && (trim_code > code_min)) begin
                trim_code <= trim_code - code_step;   // Drop one stage, speed up
            end
        end
    end

    // Lock tracking
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            run_cnt <= '0;
            locked  <= 1'b0;
        end else if (period_valid) begin
            if (!in_band) begin
                run_cnt <= '0;                     // Any miss restarts the run
                locked  <= 1'b0;
            end else if (run_cnt != lock_run) begin
                run_cnt <= run_cnt + 3'd1;         // Stops counting once run is complete
                if (run_cnt == lock_run - 3'd1) begin
                    locked <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/fll_trim_encoder.sv
// Trim encoder turning the code into an interleaved thermometer word, with DCO override
`timescale 1ns/100ps
`default_nettype none

module fll_trim_encoder #(
    parameter int num_stages = fll_cfg_pkg::num_stages  // Stages per chain
) (
    input  logic                      clock,       // Ring oscillator output
    input  logic                      arst_n,      // Async reset, active low
    input  fll_cfg_pkg::code_t        trim_code,   // Number of trim bits to set
    input  logic                      dco,         // DCO mode, external trim wins
    input  logic [2*num_stages-1:0]   ext_trim,    // External trim word
    output logic [2*num_stages-1:0]   trim         // Trim bits to both delay chains
);

    import fll_cfg_pkg::*;

    logic [2*num_stages-1:0] therm;                // Interleaved thermometer of trim_code

    // Fill order 0, ns, 1, ns+1, ...
    // Even fill position 2i is chain A bit i, odd position 2i+1 is chain B bit ns+i
    always_comb begin
        int code_i;

        code_i = int'(trim_code);
        therm  = '0;
        for (int i = 0; i < num_stages; i++) begin
            therm[i]              = code_i > (2 * i);      // Chain A, stage i
            therm[num_stages + i] = code_i > (2 * i + 1);  // Chain B, stage i
        end
    end

    // Output register, one cycle after any input change
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            trim <= '0;
        end else begin
            trim <= dco ? ext_trim : therm;        // DCO mode passes ext_trim unchanged
        end
    end

endmodule

`default_nettype wire

//--- hw/digital_fll.sv
// Digital FLL top level with osc sampler, trim controller and trim encoder
`timescale 1ns/100ps
`default_nettype none

module digital_fll #(
    parameter int sync_stages = 2,                       // Osc synchronizer depth
    parameter int num_stages  = fll_cfg_pkg::num_stages  // Stages per delay chain
) (
    input  logic                     clock,        // Ring oscillator output, fed back
    input  logic                     arst_n,       // Async reset, active low
    input  logic                     enable,       // Run measurements
    input  logic                     osc,          // Reference to lock to
    input  fll_cfg_pkg::div_t        div,          // Feedback ratio
    input  logic                     dco,          // Apply ext_trim directly
    input  logic [2*num_stages-1:0]  ext_trim,     // External trim for DCO mode
    output logic [2*num_stages-1:0]  trim,         // Trim bits to the ring oscillator
    output logic                     locked        // Frequency within band
);

    import fll_cfg_pkg::*;

    count_t period_count;                          // Sampler to controller, measurement
    logic   period_valid;                          // Sampler to controller, strobe
    code_t  trim_code;                             // Controller to encoder

    // Decode, measure clock cycles per osc period
    fll_osc_sampler #(
        .sync_stages  (sync_stages)
    ) osc_sampler0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .enable       (enable),
        .osc          (osc),
        .period_count (period_count),
        .period_valid (period_valid)
    );

    // Execute, step the trim code and track lock
    fll_trim_controller #(
        .num_stages   (num_stages)
    ) trim_controller0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .div          (div),
        .period_count (period_count),
        .period_valid (period_valid),
        .trim_code    (trim_code),
        .locked       (locked)
    );

    // Result, encode the code or pass the external trim
    fll_trim_encoder #(
        .num_stages   (num_stages)
    ) trim_encoder0 (
        .clock        (clock),
        .arst_n       (arst_n),
        .trim_code    (trim_code),
        .dco          (dco),
        .ext_trim     (ext_trim),
        .trim         (trim)
    );

endmodule

`default_nettype wire

//--- test/fll_dco_model.sv
// Behavioral ring oscillator model whose period follows the number of set trim bits
`timescale 1ns/100ps

module fll_dco_model #(
    parameter int  num_stages   = 13,              // Stages per delay chain
    parameter real base_period  = 2.0,             // Ring period in ns with no trim bits set
    parameter real stage_delay  = 0.2,             // Period added per set trim bit, ns
    parameter real start_offset = 0.3              // Keeps early edges off the osc grid
) (
    input  logic                    run,           // Ring oscillates while high
    input  logic [2*num_stages-1:0] trim,          // Trim bits loading both chains
    output logic                    clock          // Ring output, fed back to the DUT
);

    real half_period;                              // Half of the current ring period

    // Period taken from trim at the start of every cycle,
    // so a trim change shows up from the next rising edge on
    initial begin
        clock = 1'b0;
        #(start_offset);
        forever begin
            if (!run) begin
                clock = 1'b0;                      // Parked low while switched off
                wait (run);
            end
            half_period = (base_period + stage_delay * $countones(trim)) / 2.0;
            #(half_period);
            clock = 1'b1;
            #(half_period);
            clock = 1'b0;
        end
    end

endmodule

//--- test/tb_digital_fll.sv
// Testbench for the digital FLL with reference clock, stimulus, assertions, watchdog, summary
`timescale 1ns/100ps

module tb_digital_fll;

    import fll_cfg_pkg::*;
    import fll_ctrl_pkg::*;

    localparam int trim_w         = 2 * num_stages;
    localparam int osc_period     = 40;            // Reference period in ns
    localparam int osc_tenths     = osc_period * 10;
    localparam int base_tenths    = 20;            // Ring period with no trim, 2 ns
    localparam int stage_tenths   = 2;             // Per set trim bit, 0.2 ns
    localparam int reset_cycles   = 5;
    localparam int phase_periods  = 200;           // Osc periods per test phase
    localparam int off_periods    = 10;            // Enable low window
    localparam int resume_periods = 30;            // Run after enable returns
    localparam int total_periods  = reset_cycles + 3 * phase_periods
                                    + off_periods + resume_periods;
    localparam int watchdog_ns    = 2 * total_periods * osc_period;

    logic              clock;                      // Ring model output
    logic              arst_n;
    logic              enable;
    logic              osc;                        // Reference clock
    div_t              div;
    logic              dco;
    logic [trim_w-1:0] ext_trim;
    logic [trim_w-1:0] trim;
    logic              locked;
    logic              ring_on;                    // Ring model running

    int                seed            = 97;
    int                reset_errs      = 0;
    int                shape_errs      = 0;
    int                dco_errs        = 0;
    int                enable_errs     = 0;
    int                lock_errs       = 0;
    int                edges_since_rst = 0;        // Osc edges since reset release
    int                edges_since_en  = 0;        // Osc edges since enable rose
    int                settle          = 0;        // Osc edges enabled, trim and div unchanged
    logic [trim_w-1:0] trim_seen;
    div_t              div_seen;

    digital_fll #(
        .sync_stages (2),
        .num_stages  (num_stages)
    ) dut0 (
        .clock    (clock),
        .arst_n   (arst_n),
        .enable   (enable),
        .osc      (osc),
        .div      (div),
        .dco      (dco),
        .ext_trim (ext_trim),
        .trim     (trim),
        .locked   (locked)
    );

    fll_dco_model #(
        .num_stages  (num_stages),
        .base_period (base_tenths / 10.0),
        .stage_delay (stage_tenths / 10.0)
    ) dco_model0 (
        .run   (ring_on),
        .trim  (trim),
        .clock (clock)
    );

    always #(osc_period / 2) osc = ~osc;

    // Fill order 0, ns, 1, ns+1, ... so the two chains load alternately
    function automatic logic [trim_w-1:0] therm_word(input int n);
        logic [trim_w-1:0] w;

        w = '0;
        for (int p = 0; p < n; p++) begin
            if (p % 2 == 0) begin
                w[p / 2] = 1'b1;                   // Chain A takes even positions
            end else begin
                w[num_stages + p / 2] = 1'b1;      // Chain B takes odd positions
            end
        end
        return w;
    endfunction

    // A period can hold the floor or the ceiling of the exact cycle ratio
    function automatic bit count_in_band(input logic [trim_w-1:0] word, input div_t target);
        int period;
        int lo;
        int hi;

        period = base_tenths + stage_tenths * $countones(word);
        lo     = osc_tenths / period;
        hi     = (osc_tenths + period - 1) / period;
        return (lo <= int'(target) + int'(band_tol)) && (hi + int'(band_tol) >= int'(target));
    endfunction

    function automatic div_t pick_div();
        int r;

        r = $random(seed);
        return div_t'(5 + ($unsigned(r) % 14));    // 5 .. 18, reachable by the ring
    endfunction

    // Osc edge bookkeeping, old values of the driven inputs are seen here
    always @(posedge osc) begin
        if (!arst_n) begin
            edges_since_rst <= 0;
        end else if (edges_since_rst < 3) begin
            edges_since_rst <= edges_since_rst + 1;
        end
        if (!enable) begin
            edges_since_en <= 0;
        end else if (edges_since_en < 3) begin
            edges_since_en <= edges_since_en + 1;
        end
        if (!enable || trim != trim_seen || div != div_seen) begin
            settle <= 0;                           // Last measurement may mix settings
        end else if (settle < 7) begin
            settle <= settle + 1;
        end
        trim_seen <= trim;
        div_seen  <= div;
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        edges_since_rst == 0 |-> trim == '0)
    else begin
        reset_errs++;
        $display("MISMATCH trim after reset: got %h expected %h", $sampled(trim), 26'h0);
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        edges_since_rst == 0 |-> !locked)
    else begin
        reset_errs++;
        $display("MISMATCH locked after reset: got %h expected %h", $sampled(locked), 1'b0);
    end

    // Thermometer shape whenever the loop owns trim
    assert property (@(posedge clock) disable iff (!arst_n)
        !$past(dco) |-> trim == therm_word($countones(trim)))
    else begin
        shape_errs++;
        $display("MISMATCH trim shape: got %h expected %h",
                 $sampled(trim), therm_word($countones($sampled(trim))));
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        !$past(dco) && !$past(dco, 2) |-> $countones(trim ^ $past(trim)) <= 1)
    else begin
        shape_errs++;
        $display("MISMATCH trim step: from %h to %h", $past(trim), $sampled(trim));
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        $past(dco) |-> trim == $past(ext_trim))
    else begin
        dco_errs++;
        $display("MISMATCH trim in DCO mode: got %h expected %h",
                 $sampled(trim), $past(ext_trim));
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        !enable && !dco |-> $stable(trim))
    else begin
        enable_errs++;
        $display("MISMATCH trim while disabled: from %h to %h", $past(trim), $sampled(trim));
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        enable && !$past(dco) && $changed(trim) |-> edges_since_en >= 1)
    else begin
        enable_errs++;
        $display("trim changed before the second osc edge after enable returned");
    end

    // Lock must mean the ring really runs within the band
    // Trim and div also have to match their values at the last osc edge
    assert property (@(posedge clock) disable iff (!arst_n)
        locked && settle >= 3 && trim == trim_seen && div == div_seen
        |-> count_in_band(trim, div))
    else begin
        lock_errs++;
        $display("MISMATCH locked: got %h with trim %h and div %h, count out of band",
                 $sampled(locked), $sampled(trim), $sampled(div));
    end

    task automatic run_lock_phase();
        bit lock_seen;

        lock_seen = 1'b0;
        repeat (phase_periods) begin
            @(posedge osc);
            lock_seen = lock_seen | locked;
        end
        assert (lock_seen) else begin
            lock_errs++;
            $display("locked did not rise within %0d osc periods for div %h", phase_periods, div);
        end
    endtask

    // Ring keeps running one osc period after enable falls so the sampler sees it
    // New div lies far from the locked one, so the loop must step once enabled again
    task automatic pause_and_resume();
        enable <= 1'b0;
        div    <= (div < 5'd12) ? div_t'(18) : div_t'(5);
        @(posedge osc);
        ring_on <= 1'b0;
        repeat (off_periods - 1) @(posedge osc);
        enable  <= 1'b1;
        ring_on <= 1'b1;
        repeat (resume_periods) @(posedge osc);
    endtask

    task automatic run_dco_phase();
        ext_trim <= trim;                          // Start from the loop's last trim
        dco      <= 1'b1;
        for (int i = 0; i < phase_periods; i++) begin
            @(posedge osc);
            if (i % 25 == 24) begin
                ext_trim <= trim_w'($random(seed)); // Held long enough to settle
            end
        end
    endtask

    initial begin
        osc      = 1'b0;
        arst_n   = 1'b0;
        enable   = 1'b1;
        dco      = 1'b0;
        ring_on  = 1'b1;
        ext_trim = '0;
        div      = pick_div();
        repeat (reset_cycles) @(posedge osc);
        arst_n <= 1'b1;
        run_lock_phase();                          // Lock from code 0
        div <= pick_div();
        run_lock_phase();                          // Relock from the previous trim
        pause_and_resume();
        run_dco_phase();
        $display("errors: reset %0d, shape %0d, dco %0d, enable %0d, lock %0d",
                 reset_errs, shape_errs, dco_errs, enable_errs, lock_errs);
        if (reset_errs + shape_errs + dco_errs + enable_errs + lock_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns * 1ns);
        $display("Timeout, run did not finish within %0d ns", watchdog_ns);
        $display("sim failed");
        $finish;
    end

endmodule

//--- digital_fll.f
hw/fll_cfg_pkg.sv
hw/fll_ctrl_pkg.sv
hw/fll_osc_sampler.sv
hw/fll_trim_controller.sv
hw/fll_trim_encoder.sv
hw/digital_fll.sv
test/fll_dco_model.sv
test/tb_digital_fll.sv

//--- Bender.yml
package:
  name: digital_fll

dependencies: {}

sources:
  # Packages first, the RTL imports them
  - files:
      - hw/fll_cfg_pkg.sv
      - hw/fll_ctrl_pkg.sv

  # RTL, leaves before the top level
  - files:
      - hw/fll_osc_sampler.sv
      - hw/fll_trim_controller.sv
      - hw/fll_trim_encoder.sv
      - hw/digital_fll.sv

  # Ring oscillator model and testbench top
  - target: test
    files:
      - test/fll_dco_model.sv
      - test/tb_digital_fll.sv
